/* dv/axis_stream_in_input.txt */
# op field1 field2, hex: W addr data | R addr expect | S data flags | B first count
# D expect 0 | T tready 0 | C cycles 0 | I expect 0 (S flags: bit0 tlast, bit4 refused)
W 04 1
W 08 4
T 1 0
C 08 0
B a0000001 5
D a0000001 0
D a0000002 0
D a0000003 0
D a0000004 0
D a0000005 0
# cpu reads of DATA
T 0 0
S b0000001 0
S b0000002 0
S b0000003 0
C 10 0
R 0c b0000001
R 0c b0000002
R 0c b0000003
R 10 1
R 0c 0
# enable off, then fill to 17 words
W 04 0
C 08 0
S dead0000 10
W 04 1
C 08 0
B c0000000 11
S c0000011 10
S c0000012 10
S c0000013 10
R 14 11
R 10 2
W 00 1
C 0a 0
W 00 0
C 0a 0
R 14 0
# frame with tlast on beat 6
B d0000001 5
S d0000006 1
B d0000007 2
C 10 0
R 18 6
R 10 4
# soft reset keeps ENABLE and THRESHOLD
W 00 1
C 0a 0
W 00 0
C 0a 0
R 18 0
R 10 1
R 14 0
R 04 1
R 08 4
# threshold interrupt
B e0000001 3
C 10 0
I 0 0
R 14 3
S e0000004 0
C 10 0
I 1 0
R 14 4

/* compile.f */
src/axis_in_pkg.sv
src/axis_in_sync.sv
src/axis_in_fifo_async.sv
src/axis_in_frame_mon.sv
src/axis_in_csr.sv
src/axis_stream_in.sv
dv/axis_stream_in_asserts.sv
dv/axis_stream_in_tb.sv

/* dv/axis_stream_in_tb.sv */
`timescale 1ns/1ps

module axis_stream_in_tb
   import axis_in_pkg::*;
();

   localparam int RST_CYCLES      = 5;
   localparam int CYCLES_PER_LINE = 200;
   localparam int REFUSE_CYCLES   = 8;

   logic        clk_i;
   logic        axis_clk_i;
   logic        rst_i;
   logic        iob_valid_i;
   csr_addr_t   iob_addr_i;
   data_t       iob_wdata_i;
   logic [3:0]  iob_wstrb_i;
   logic        iob_ready_o;
   logic        iob_rvalid_o;
   data_t       iob_rdata_o;
   logic        axis_tvalid_i;
   data_t       axis_tdata_i;
   logic        axis_tlast_i;
   logic        axis_tready_o;
   logic        dma_tvalid_o;
   data_t       dma_tdata_o;
   logic        dma_tready_i;
   logic        interrupt_o;

   logic [7:0]  cmd_op [$];
   logic [31:0] cmd_a [$];
   logic [31:0] cmd_b [$];
   data_t       dma_seen [$];
   logic        dma_valid_s;
   data_t       dma_data_s;

   int          seed = 32'hf390;
   int          errors = 0;
   int          checks = 0;
   int          assert_fails = 0;
   int          cycles = 0;
   int          cycle_limit = 0;

   axis_stream_in axis_stream_in_inst (.*);

   always #5 clk_i = ~clk_i;
   always #7 axis_clk_i = ~axis_clk_i;

   // outputs only move on the rising edge, so take them at the falling one
   always @(negedge clk_i) begin
      dma_valid_s = dma_tvalid_o;
      dma_data_s  = dma_tdata_o;
   end

   always @(posedge clk_i) begin
      if (!rst_i && dma_valid_s && dma_tready_i) begin
         dma_seen.push_back(dma_data_s);
      end
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit) begin
         $display("timeout after %0d clk cycles, the script did not complete", cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   task automatic load_script();
      int         fd;
      int         n;
      string      line;
      logic [7:0] op;
      logic [31:0] a;
      logic [31:0] b;
      fd = $fopen("dv/axis_stream_in_input.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("could not open the stimulus file dv/axis_stream_in_input.txt");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         n = $sscanf(line, "%c %h %h", op, a, b);
         // comment and blank lines do not give three fields
         if (n == 3 && op != "#") begin
            cmd_op.push_back(op);
            cmd_a.push_back(a);
            cmd_b.push_back(b);
         end
      end
      $fclose(fd);
   endtask

   // every request is accepted in the cycle it is presented
   task automatic check_ready();
      checks++;
      if (iob_ready_o !== 1'b1) begin
         errors++;
         $display("[FAIL] iob_ready_o: got %h, expected %h", iob_ready_o, 1'b1);
      end
   endtask

   task automatic reg_write(input csr_addr_t addr, input data_t data);
      @(negedge clk_i);
      iob_valid_i = 1'b1;
      iob_addr_i  = addr;
      iob_wdata_i = data;
      iob_wstrb_i = 4'hf;
      @(negedge clk_i);
      check_ready();
      iob_valid_i = 1'b0;
      iob_wstrb_i = 4'h0;
   endtask

   task automatic reg_read(input csr_addr_t addr, input data_t exp_data);
      @(negedge clk_i);
      iob_valid_i = 1'b1;
      iob_addr_i  = addr;
      iob_wstrb_i = 4'h0;
      @(negedge clk_i);
      check_ready();
      iob_valid_i = 1'b0;
      checks++;
      if (iob_rvalid_o !== 1'b1) begin
         errors++;
         $display("rvalid missing one cycle after the read of address %h", addr);
      end else if (iob_rdata_o !== exp_data) begin
         errors++;
         $display("[FAIL] iob_rdata_o at address %h: got %h, expected %h",
                  addr, iob_rdata_o, exp_data);
      end
   endtask

   task automatic send_beat(input data_t data, input logic last, input logic refused);
      logic taken;
      int   gap;
      taken = 1'b0;
      gap   = $unsigned($random(seed)) % 3;
      repeat (gap) @(negedge axis_clk_i);
      @(negedge axis_clk_i);
      axis_tvalid_i = 1'b1;
      axis_tdata_i  = data;
      axis_tlast_i  = last;
      if (refused) begin
         repeat (REFUSE_CYCLES) begin
            taken = taken || axis_tready_o;
            @(negedge axis_clk_i);
         end
         checks++;
         if (taken) begin
            errors++;
            $display("beat %h was accepted while the stream input should stall", data);
         end
      end else begin
         // tready only moves on the rising edge
         while (!taken) begin
            taken = axis_tready_o;
            @(negedge axis_clk_i);
         end
      end
      axis_tvalid_i = 1'b0;
      axis_tlast_i  = 1'b0;
   endtask

   task automatic send_burst(input data_t first, input int count);
      for (int i = 0; i < count; i++) begin
         send_beat(first + data_t'(i), 1'b0, 1'b0);
      end
   endtask

   task automatic dma_pop(input data_t exp_data);
      data_t got;
      while (dma_seen.size() == 0) begin
         @(negedge clk_i);
      end
      got = dma_seen.pop_front();
      checks++;
      if (got !== exp_data) begin
         errors++;
         $display("[FAIL] dma_tdata_o: got %h, expected %h", got, exp_data);
      end
   endtask

   task automatic check_irq(input logic exp_val);
      @(negedge clk_i);
      checks++;
      if (interrupt_o !== exp_val) begin
         errors++;
         $display("[FAIL] interrupt_o: got %h, expected %h", interrupt_o, exp_val);
      end
   endtask

   task automatic run_command(input logic [7:0] op, input logic [31:0] a, input logic [31:0] b);
      case (op)
         "W": reg_write(csr_addr_t'(a), b);
         "R": reg_read(csr_addr_t'(a), b);
         "S": send_beat(a, b[0], b[4]);
         "B": send_burst(a, b);
         "D": dma_pop(a);
         "T": begin
            @(negedge clk_i);
            dma_tready_i = a[0];
         end
         "C": repeat (a) @(negedge clk_i);
         "I": check_irq(a[0]);
         default: begin
            errors++;
            $display("unknown opcode %c in the stimulus file", op);
         end
      endcase
   endtask

   initial begin
      clk_i         = 1'b0;
      axis_clk_i    = 1'b0;
      rst_i         = 1'b1;
      iob_valid_i   = 1'b0;
      iob_addr_i    = '0;
      iob_wdata_i   = '0;
      iob_wstrb_i   = 4'h0;
      axis_tvalid_i = 1'b0;
      axis_tdata_i  = '0;
      axis_tlast_i  = 1'b0;
      dma_tready_i  = 1'b0;
      load_script();
      // one extra line's worth for reset
      cycle_limit = CYCLES_PER_LINE * (cmd_op.size() + 1);
      repeat (RST_CYCLES) @(negedge clk_i);
      rst_i = 1'b0;
      repeat (4) @(negedge clk_i);
      for (int i = 0; i < cmd_op.size(); i++) begin
         run_command(cmd_op[i], cmd_a[i], cmd_b[i]);
      end
      repeat (4) @(negedge clk_i);
      if (dma_seen.size() != 0) begin
         errors++;
         $display("%0d words left the DMA port without a matching check", dma_seen.size());
      end
      assert_fails = axis_stream_in_inst.asserts_inst.fail_count;
      $display("checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* dv/axis_stream_in_asserts.sv */
`timescale 1ns/1ps

module axis_stream_in_asserts import axis_in_pkg::*; (
   input logic       clk_i,
   input logic       rst_i,
   input logic       iob_valid_i,
   input logic [3:0] iob_wstrb_i,
   input logic       iob_rvalid_o,
   input logic       axis_tready_o,
   input logic       dma_tvalid_o,
   input data_t      dma_tdata_o,
   input logic       dma_tready_i,
   input logic       interrupt_o,
   input logic       data_ren_i,
   input level_t     level_i
);

   int unsigned fail_count = 0;
   logic        read_req;

   assign read_req = iob_valid_i && (iob_wstrb_i == 4'h0);

   rvalid_latency: assert property (@(posedge clk_i) disable iff (rst_i)
      iob_rvalid_o == $past(read_req))
   else begin
      fail_count++;
      $error("iob_rvalid_o does not follow the read request by one cycle");
   end

   // a CPU pop may replace the held word
   dma_data_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      dma_tvalid_o && !dma_tready_i && !data_ren_i |=> $stable(dma_tdata_o))
   else begin
      fail_count++;
      $error("dma_tdata_o changed while the word was stalled");
   end

   full_stalls_stream: assert property (@(posedge clk_i) disable iff (rst_i)
      level_i == level_t'(17) |-> !axis_tready_o)
   else begin
      fail_count++;
      $error("axis_tready_o high with 17 words stored");
   end

   reset_values: assert property (@(posedge clk_i)
      $fell(rst_i) |-> !dma_tvalid_o && !iob_rvalid_o && !interrupt_o && !axis_tready_o)
   else begin
      fail_count++;
      $error("outputs not at their reset values after reset");
   end

endmodule

bind axis_stream_in axis_stream_in_asserts asserts_inst (
   .clk_i         (clk_i),
   .rst_i         (rst_i),
   .iob_valid_i   (iob_valid_i),
   .iob_wstrb_i   (iob_wstrb_i),
   .iob_rvalid_o  (iob_rvalid_o),
   .axis_tready_o (axis_tready_o),
   .dma_tvalid_o  (dma_tvalid_o),
   .dma_tdata_o   (dma_tdata_o),
   .dma_tready_i  (dma_tready_i),
   .interrupt_o   (interrupt_o),
   .data_ren_i    (data_ren),
   .level_i       (level)
);

/* src/axis_stream_in.sv */
`timescale 1ns/1ps

module axis_stream_in import axis_in_pkg::*; (
   input  logic       clk_i,
   input  logic       axis_clk_i,
   input  logic       rst_i,
   input  logic       iob_valid_i,
   input  csr_addr_t  iob_addr_i,
   input  data_t      iob_wdata_i,
   input  logic [3:0] iob_wstrb_i,
   output logic       iob_ready_o,
   output logic       iob_rvalid_o,
   output data_t      iob_rdata_o,
   input  logic       axis_tvalid_i,
   input  data_t      axis_tdata_i,
   input  logic       axis_tlast_i,
   output logic       axis_tready_o,
   output logic       dma_tvalid_o,
   output data_t      dma_tdata_o,
   input  logic       dma_tready_i,
   output logic       interrupt_o
);

   logic      soft_reset;
   logic      enable;
   level_t    threshold;
   logic      data_ren;
   logic      tlast_detected;
   data_t     nwords;

   logic      axis_rst;
   logic      axis_sw_rst;
   logic      axis_enable;
   logic      axis_stream_rst;
   logic      axis_full;
   logic      axis_beat;
   logic      axis_tlast_detected;
   data_t     axis_word_count;

   logic      fifo_rst;
   logic      fifo_rd;
   logic      fifo_empty;
   logic      fifo_full;
   level_t    fifo_level;
   level_t    level;
   logic      consume;
   rd_state_t rd_state;
   rd_state_t rd_state_nxt;

   axis_in_csr csr_inst (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .iob_valid_i      (iob_valid_i),
      .iob_addr_i       (iob_addr_i),
      .iob_wdata_i      (iob_wdata_i),
      .iob_wstrb_i      (iob_wstrb_i),
      .iob_ready_o      (iob_ready_o),
      .iob_rvalid_o     (iob_rvalid_o),
      .iob_rdata_o      (iob_rdata_o),
      .soft_reset_o     (soft_reset),
      .enable_o         (enable),
      .threshold_o      (threshold),
      .data_ren_o       (data_ren),
      .data_i           (dma_tdata_o),
      .data_held_i      (dma_tvalid_o),
      .empty_i          (fifo_empty && !dma_tvalid_o),
      .full_i           (fifo_full),
      .tlast_detected_i (tlast_detected),
      .level_i          (level),
      .nwords_i         (nwords)
   );

   // system reset into the stream domain
   axis_in_sync #(.WIDTH(1)) rst_sync (
      .clk_i (axis_clk_i),
      .rst_i (1'b0),
      .d_i   (rst_i),
      .q_o   (axis_rst)
   );

   axis_in_sync #(.WIDTH(2)) ctrl_sync (
      .clk_i (axis_clk_i),
      .rst_i (axis_rst),
      .d_i   ({soft_reset, enable}),
      .q_o   ({axis_sw_rst, axis_enable})
   );

   assign axis_stream_rst = axis_rst || axis_sw_rst;
   assign axis_tready_o   = axis_enable && !axis_full;
   assign axis_beat       = axis_tvalid_i && axis_tready_o;

   axis_in_frame_mon frame_mon_inst (
      .axis_clk_i       (axis_clk_i),
      .rst_i            (axis_stream_rst),
      .beat_i           (axis_beat),
      .tlast_i          (axis_tlast_i),
      .word_count_o     (axis_word_count),
      .tlast_detected_o (axis_tlast_detected)
   );

   axis_in_sync #(.WIDTH(1)) tlast_sync (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .d_i   (axis_tlast_detected),
      .q_o   (tlast_detected)
   );

   // count is frozen once tlast is seen, so sampling it after the flag is safe
   axis_in_sync #(.WIDTH(DATA_W)) count_sync (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .d_i   (axis_word_count),
      .q_o   (nwords)
   );

   assign fifo_rst = rst_i || soft_reset;

   axis_in_fifo_async fifo_inst (
      .w_clk_i   (axis_clk_i),
      .w_rst_i   (axis_stream_rst),
      .w_en_i    (axis_beat),
      .w_data_i  (axis_tdata_i),
      .w_full_o  (axis_full),
      .r_clk_i   (clk_i),
      .r_rst_i   (fifo_rst),
      .r_en_i    (fifo_rd),
      .r_data_o  (dma_tdata_o),
      .r_empty_o (fifo_empty),
      .r_full_o  (fifo_full),
      .r_level_o (fifo_level)
   );

   // fifo read register is the held word
   assign dma_tvalid_o = (rd_state == RD_HOLD);
   assign consume      = dma_tvalid_o && (dma_tready_i || data_ren);

   always_comb begin
      rd_state_nxt = rd_state;
      fifo_rd      = 1'b0;
      case (rd_state)
         RD_IDLE: begin
            if (!fifo_empty) begin
               fifo_rd      = 1'b1;
               rd_state_nxt = RD_HOLD;
            end
         end
         RD_HOLD: begin
            // prefetch the next word on the same edge as the pop
            if (consume) begin
               if (fifo_empty) begin
                  rd_state_nxt = RD_IDLE;
               end else begin
                  fifo_rd = 1'b1;
               end
            end
         end
         default: rd_state_nxt = RD_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (fifo_rst) begin
         rd_state <= RD_IDLE;
      end else begin
         rd_state <= rd_state_nxt;
      end
   end

   assign level = fifo_level + level_t'(dma_tvalid_o);

   // threshold of 0 keeps the interrupt off
   assign interrupt_o = (threshold != '0) && (level >= threshold);

endmodule

/* src/axis_in_csr.sv */
`timescale 1ns/1ps

module axis_in_csr import axis_in_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       iob_valid_i,
   input  csr_addr_t  iob_addr_i,
   input  data_t      iob_wdata_i,
   input  logic [3:0] iob_wstrb_i,
   output logic       iob_ready_o,
   output logic       iob_rvalid_o,
   output data_t      iob_rdata_o,
   output logic       soft_reset_o,
   output logic       enable_o,
   output level_t     threshold_o,
   output logic       data_ren_o,
   input  data_t      data_i,
   input  logic       data_held_i,
   input  logic       empty_i,
   input  logic       full_i,
   input  logic       tlast_detected_i,
   input  level_t     level_i,
   input  data_t      nwords_i
);

   logic  req_wr;
   logic  req_rd;
   data_t rd_mux;

   assign iob_ready_o = 1'b1;
   assign req_wr      = iob_valid_i && (iob_wstrb_i != '0);
   assign req_rd      = iob_valid_i && (iob_wstrb_i == '0);
   // a DATA read pops only when a word is there
   assign data_ren_o  = req_rd && (iob_addr_i == ADDR_DATA) && data_held_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         soft_reset_o <= 1'b0;
         enable_o     <= 1'b0;
         threshold_o  <= '0;
      end else if (req_wr) begin
         case (iob_addr_i)
            ADDR_SOFT_RESET: soft_reset_o <= iob_wdata_i[0];
            ADDR_ENABLE:     enable_o     <= iob_wdata_i[0];
            ADDR_THRESHOLD:  threshold_o  <= iob_wdata_i[LEVEL_W-1:0];
            default: ;
         endcase
      end
   end

   always_comb begin
      case (iob_addr_i)
         ADDR_SOFT_RESET: rd_mux = data_t'(soft_reset_o);
         ADDR_ENABLE:     rd_mux = data_t'(enable_o);
         ADDR_THRESHOLD:  rd_mux = data_t'(threshold_o);
         ADDR_DATA:       rd_mux = data_held_i ? data_i : '0;
         ADDR_STATUS:     rd_mux = data_t'({tlast_detected_i, full_i, empty_i});
         ADDR_LEVEL:      rd_mux = data_t'(level_i);
         ADDR_NWORDS:     rd_mux = nwords_i;
         default:         rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         iob_rvalid_o <= 1'b0;
      end else begin
         iob_rvalid_o <= req_rd;
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_rd) begin
         iob_rdata_o <= rd_mux;
      end
   end

endmodule

/* src/axis_in_frame_mon.sv */
`timescale 1ns/1ps

module axis_in_frame_mon import axis_in_pkg::*; (
   input  logic  axis_clk_i,
   input  logic  rst_i,
   input  logic  beat_i,
   input  logic  tlast_i,
   output data_t word_count_o,
   output logic  tlast_detected_o
);

   logic count_en;

   // the tlast beat itself still counts
   assign count_en = beat_i && !tlast_detected_o;

   always_ff @(posedge axis_clk_i) begin
      if (rst_i) begin
         word_count_o     <= '0;
         tlast_detected_o <= 1'b0;
      end else if (count_en) begin
         word_count_o <= word_count_o + 1'b1;
         if (tlast_i) begin
            tlast_detected_o <= 1'b1;
         end
      end
   end

endmodule

/* src/axis_in_fifo_async.sv */
`timescale 1ns/1ps

module axis_in_fifo_async import axis_in_pkg::*; (
   // write side
   input  logic   w_clk_i,
   input  logic   w_rst_i,
   input  logic   w_en_i,
   input  data_t  w_data_i,
   output logic   w_full_o,
   // read side
   input  logic   r_clk_i,
   input  logic   r_rst_i,
   input  logic   r_en_i,
   output data_t  r_data_o,
   output logic   r_empty_o,
   output logic   r_full_o,
   output level_t r_level_o
);

   data_t                mem [2**FIFO_ADDR_W];

   logic [FIFO_ADDR_W:0] w_bin;
   logic [FIFO_ADDR_W:0] w_bin_nxt;
   logic [FIFO_ADDR_W:0] w_gray;
   logic [FIFO_ADDR_W:0] r_gray_wsync;
   fifo_addr_t           w_addr;

   logic [FIFO_ADDR_W:0] r_bin;
   logic [FIFO_ADDR_W:0] r_bin_nxt;
   logic [FIFO_ADDR_W:0] r_gray;
   logic [FIFO_ADDR_W:0] w_gray_rsync;
   logic [FIFO_ADDR_W:0] w_bin_rsync;
   fifo_addr_t           r_addr;

   function automatic logic [FIFO_ADDR_W:0] bin2gray(input logic [FIFO_ADDR_W:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [FIFO_ADDR_W:0] gray2bin(input logic [FIFO_ADDR_W:0] g);
      logic [FIFO_ADDR_W:0] b;
      b[FIFO_ADDR_W] = g[FIFO_ADDR_W];
      for (int i = FIFO_ADDR_W - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   assign w_bin_nxt = w_bin + 1'b1;
   assign w_addr    = w_bin[FIFO_ADDR_W-1:0];
   // full when the gray pointers differ only in the two top bits
   assign w_full_o  = (w_gray == {~r_gray_wsync[FIFO_ADDR_W:FIFO_ADDR_W-1],
                                  r_gray_wsync[FIFO_ADDR_W-2:0]});

   always_ff @(posedge w_clk_i) begin
      if (w_rst_i) begin
         w_bin  <= '0;
         w_gray <= '0;
      end else if (w_en_i && !w_full_o) begin
         w_bin  <= w_bin_nxt;
         w_gray <= bin2gray(w_bin_nxt);
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (w_en_i && !w_full_o && !w_rst_i) begin
         mem[w_addr] <= w_data_i;
      end
   end

   axis_in_sync #(.WIDTH(FIFO_ADDR_W + 1)) r_ptr_sync (
      .clk_i (w_clk_i),
      .rst_i (w_rst_i),
      .d_i   (r_gray),
      .q_o   (r_gray_wsync)
   );

   assign r_bin_nxt   = r_bin + 1'b1;
   assign r_addr      = r_bin[FIFO_ADDR_W-1:0];
   assign w_bin_rsync = gray2bin(w_gray_rsync);
   assign r_empty_o   = (r_gray == w_gray_rsync);
   assign r_full_o    = (w_gray_rsync == {~r_gray[FIFO_ADDR_W:FIFO_ADDR_W-1],
                                          r_gray[FIFO_ADDR_W-2:0]});
   assign r_level_o   = level_t'(w_bin_rsync - r_bin);

   always_ff @(posedge r_clk_i) begin
      if (r_rst_i) begin
         r_bin  <= '0;
         r_gray <= '0;
      end else if (r_en_i && !r_empty_o) begin
         r_bin  <= r_bin_nxt;
         r_gray <= bin2gray(r_bin_nxt);
      end
   end

   // registered read, holds its value until the next pop
   always_ff @(posedge r_clk_i) begin
      if (r_en_i && !r_empty_o && !r_rst_i) begin
         r_data_o <= mem[r_addr];
      end
   end

   axis_in_sync #(.WIDTH(FIFO_ADDR_W + 1)) w_ptr_sync (
      .clk_i (r_clk_i),
      .rst_i (r_rst_i),
      .d_i   (w_gray),
      .q_o   (w_gray_rsync)
   );

endmodule

/* src/axis_in_sync.sv */
`timescale 1ns/1ps

module axis_in_sync #(
   parameter int WIDTH = 1
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic [WIDTH-1:0] d_i,
   output logic [WIDTH-1:0] q_o
);

   logic [WIDTH-1:0] meta;

   // two stages into the destination clock
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         meta <= '0;
         q_o  <= '0;
      end else begin
         meta <= d_i;
         q_o  <= meta;
      end
   end

endmodule

/* src/axis_in_pkg.sv */
package axis_in_pkg;

   // data path and fifo geometry
   localparam int DATA_W      = 32;
   localparam int FIFO_ADDR_W = 4;
   // 16 in the fifo plus one held word
   localparam int LEVEL_W     = 6;
   localparam int ADDR_W      = 5;

   typedef logic [DATA_W-1:0]      data_t;
   typedef logic [FIFO_ADDR_W-1:0] fifo_addr_t;
   typedef logic [LEVEL_W-1:0]     level_t;
   typedef logic [ADDR_W-1:0]      csr_addr_t;

   // register byte offsets
   localparam csr_addr_t ADDR_SOFT_RESET = 5'h00;
   localparam csr_addr_t ADDR_ENABLE     = 5'h04;
   localparam csr_addr_t ADDR_THRESHOLD  = 5'h08;
   localparam csr_addr_t ADDR_DATA       = 5'h0C;
   localparam csr_addr_t ADDR_STATUS     = 5'h10;
   localparam csr_addr_t ADDR_LEVEL      = 5'h14;
   localparam csr_addr_t ADDR_NWORDS     = 5'h18;

   // read controller
   typedef enum logic {
      RD_IDLE,
      RD_HOLD
   } rd_state_t;

endpackage
